//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim
	./obj_dir/cpu_sim | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- logic/bus_unit.sv
// bus source multiplexer, output register and its one-cycle valid strobe
`timescale 1ns/1ps

module bus_unit #(
    parameter int DATA_W = cpu_pkg::DATA_W
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::ADDR_W-1:0] pc_value,
    input  logic [DATA_W-1:0]          ram_value,
    input  logic [cpu_pkg::ADDR_W-1:0] operand,
    input  logic [DATA_W-1:0]          acc_value,
    input  logic [DATA_W-1:0]          alu_value,
    ctrl_if.bus                        ctl,
    output logic [DATA_W-1:0]          bus_value,
    output logic [DATA_W-1:0]          out_value,
    output logic                       out_valid
);
    import cpu_pkg::*;

    // padding for the 4-bit sources
    localparam int PAD_W = DATA_W - ADDR_W;

    // one driver per cycle, idle bus reads as zero
    always_comb begin
        case (ctl.bus_src)
            BUS_PC:         bus_value = {{PAD_W{1'b0}}, pc_value};
            BUS_RAM:        bus_value = ram_value;
            BUS_IR_OPERAND: bus_value = {{PAD_W{1'b0}}, operand};
            BUS_ACC:        bus_value = acc_value;
            BUS_ALU:        bus_value = alu_value;
            default:        bus_value = '0;
        endcase
    end

    // output register plus strobe
    // valid rises with the new value, one cycle after lo
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_value <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctl.lo;
            if (ctl.lo) begin
                out_value <= bus_value;
            end
        end
    end

endmodule

//--- logic/control_block.sv
// microstep counter, halted latch and microcode decode into the control word
`timescale 1ns/1ps

module control_block (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              run,
    input  cpu_pkg::opcode_e  opcode,
    input  logic              carry,
    input  logic              zero,
    ctrl_if.ctrl              ctl,
    output logic              halted
);
    import cpu_pkg::*;

    // final microstep before wrapping to T1
    localparam step_e LAST_STEP = step_e'(STEPS - 1);

    step_e step;

    // step counter
    // parked at T1 while the host loads the program, frozen once halted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step <= T1;
        end else if (!run) begin
            step <= T1;
        end else if (!halted) begin
            step <= (step == LAST_STEP) ? T1 : step_e'(step + 3'd1);
        end
    end

    // halted latch, cleared only by reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (ctl.hlt) begin
            halted <= 1'b1;
        end
    end

    // microcode table
    always_comb begin
        ctl.cp      = 1'b0;
        ctl.lp      = 1'b0;
        ctl.lma     = 1'b0;
        ctl.lr      = 1'b0;
        ctl.wr      = 1'b0;
        ctl.li      = 1'b0;
        ctl.la      = 1'b0;
        ctl.lb      = 1'b0;
        ctl.sub     = 1'b0;
        ctl.lf      = 1'b0;
        ctl.lo      = 1'b0;
        ctl.hlt     = 1'b0;
        ctl.bus_src = BUS_NONE;
        // nothing fires before run or after HLT
        if (run && !halted) begin
            case (step)
                // fetch: PC into MAR
                T1: begin
                    ctl.bus_src = BUS_PC;
                    ctl.lma     = 1'b1;
                end
                // fetch: RAM into IR, step PC
                T2: begin
                    ctl.bus_src = BUS_RAM;
                    ctl.lr      = 1'b1;
                    ctl.li      = 1'b1;
                    ctl.cp      = 1'b1;
                end
                T3: begin
                    case (opcode)
                        // address phase of memory ops
                        OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                            ctl.bus_src = BUS_IR_OPERAND;
                            ctl.lma     = 1'b1;
                        end
                        // immediate, zero-extended by the bus mux
                        OP_LDI: begin
                            ctl.bus_src = BUS_IR_OPERAND;
                            ctl.la      = 1'b1;
                        end
                        OP_JMP: begin
                            ctl.bus_src = BUS_IR_OPERAND;
                            ctl.lp      = 1'b1;
                        end
                        // conditional jumps look at the stored flags
                        OP_JC, OP_JZ: begin
                            ctl.bus_src = BUS_IR_OPERAND;
                            ctl.lp      = (opcode == OP_JC) ? carry : zero;
                        end
                        OP_OUT: begin
                            ctl.bus_src = BUS_ACC;
                            ctl.lo      = 1'b1;
                        end
                        OP_HLT: ctl.hlt = 1'b1;
                        default: ;
                    endcase
                end
                T4: begin
                    case (opcode)
                        OP_LDA: begin
                            ctl.bus_src = BUS_RAM;
                            ctl.lr      = 1'b1;
                            ctl.la      = 1'b1;
                        end
                        // second operand into B
                        OP_ADD, OP_SUB: begin
                            ctl.bus_src = BUS_RAM;
                            ctl.lr      = 1'b1;
                            ctl.lb      = 1'b1;
                        end
                        OP_STA: begin
                            ctl.bus_src = BUS_ACC;
                            ctl.wr      = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T5: begin
                    // ALU result back into A, flags follow
                    if (opcode == OP_ADD || opcode == OP_SUB) begin
                        ctl.bus_src = BUS_ALU;
                        ctl.sub     = (opcode == OP_SUB);
                        ctl.la      = 1'b1;
                        ctl.lf      = 1'b1;
                    end
                end
                // T6 is idle for every opcode
                default: ;
            endcase
        end
    end

endmodule

//--- logic/cpu_pkg.sv
// shared widths, opcode enum, microstep enum, bus source enum and RAM depth
package cpu_pkg;

    // data path and bus width
    parameter int DATA_W = 8;
    // address and operand width
    parameter int ADDR_W = 4;
    // bytes of program/data RAM
    parameter int RAM_DEPTH = 16;
    // microsteps per instruction
    parameter int STEPS = 6;

    // upper nibble of the instruction byte
    // codes 10..14 are undefined and decode as NOP
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDA = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_STA = 4'd4,
        OP_LDI = 4'd5,
        OP_JMP = 4'd6,
        OP_JC  = 4'd7,
        OP_JZ  = 4'd8,
        OP_OUT = 4'd9,
        OP_HLT = 4'd15
    } opcode_e;

    // one state per clock of an instruction
    typedef enum logic [2:0] {T1, T2, T3, T4, T5, T6} step_e;

    // who drives the internal bus this cycle
    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_RAM,
        BUS_IR_OPERAND,
        BUS_ACC,
        BUS_ALU
    } bus_src_e;

endpackage

//--- logic/cpu_top.sv
// top level of the accumulator CPU, instances and wiring of the control block and units
`timescale 1ns/1ps

module cpu_top #(
    parameter int DATA_W    = cpu_pkg::DATA_W,
    parameter int RAM_DEPTH = cpu_pkg::RAM_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       prog_we,
    input  logic [cpu_pkg::ADDR_W-1:0] prog_addr,
    input  logic [DATA_W-1:0]          prog_data,
    output logic [DATA_W-1:0]          out_value,
    output logic                       out_valid,
    output logic                       halted
);
    import cpu_pkg::*;

    // fetch side results
    logic [ADDR_W-1:0] pc_value;
    logic [DATA_W-1:0] ram_value;
    opcode_e           opcode;
    logic [ADDR_W-1:0] operand;
    // exec side results
    logic [DATA_W-1:0] acc_value;
    logic [DATA_W-1:0] alu_value;
    logic              carry;
    logic              zero;
    // shared internal bus
    logic [DATA_W-1:0] bus_value;

    ctrl_if ctl ();

    control_block u_control (
        .clk(clk), .arst_n(arst_n), .run(run), .opcode(opcode),
        .carry(carry), .zero(zero), .ctl(ctl), .halted(halted)
    );

    fetch_unit #(.DATA_W(DATA_W), .RAM_DEPTH(RAM_DEPTH)) u_fetch (
        .clk(clk), .arst_n(arst_n), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .bus_value(bus_value), .ctl(ctl),
        .pc_value(pc_value), .ram_value(ram_value), .opcode(opcode), .operand(operand)
    );

    exec_unit #(.DATA_W(DATA_W)) u_exec (
        .clk(clk), .arst_n(arst_n), .bus_value(bus_value), .ctl(ctl),
        .acc_value(acc_value), .alu_value(alu_value), .carry(carry), .zero(zero)
    );

    bus_unit #(.DATA_W(DATA_W)) u_bus (
        .clk(clk), .arst_n(arst_n), .pc_value(pc_value), .ram_value(ram_value),
        .operand(operand), .acc_value(acc_value), .alu_value(alu_value), .ctl(ctl),
        .bus_value(bus_value), .out_value(out_value), .out_valid(out_valid)
    );

endmodule

//--- logic/ctrl_if.sv
// control word interface with modports for the control block and the three units
`timescale 1ns/1ps

interface ctrl_if;
    import cpu_pkg::*;

    // program counter strobes
    logic cp;
    logic lp;
    // memory address register and RAM
    logic lma;
    logic lr;
    logic wr;
    // instruction register load
    logic li;
    // accumulator, B register and ALU
    logic la;
    logic lb;
    logic sub;
    logic lf;
    // output register load
    logic lo;
    // stop request, latched by the control block
    logic hlt;
    // bus driver select
    bus_src_e bus_src;

    // microcode drives the whole word
    modport ctrl (
        output cp, lp, lma, lr, wr, li, la, lb, sub, lf, lo, hlt, bus_src
    );

    // PC, MAR, RAM and IR side
    modport fetch (input cp, lp, lma, lr, wr, li);

    // accumulator, B and flags side
    modport exec (input la, lb, sub, lf);

    // bus mux and output register
    modport bus (input bus_src, lo);

endinterface

//--- logic/exec_unit.sv
// accumulator, B register, adder/subtractor, carry and zero flags
`timescale 1ns/1ps

module exec_unit #(
    parameter int DATA_W = cpu_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [DATA_W-1:0] bus_value,
    ctrl_if.exec              ctl,
    output logic [DATA_W-1:0] acc_value,
    output logic [DATA_W-1:0] alu_value,
    output logic              carry,
    output logic              zero
);

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] b_reg;
    // B, inverted when subtracting
    logic [DATA_W-1:0] b_operand;
    // one extra bit for carry-out
    logic [DATA_W:0]   alu_sum;

    // accumulator
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (ctl.la) begin
            acc <= bus_value;
        end
    end

    // B register, fed from RAM during ADD/SUB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            b_reg <= '0;
        end else if (ctl.lb) begin
            b_reg <= bus_value;
        end
    end

    // two's complement subtract
    // A + ~B + 1, with sub as the carry-in
    assign b_operand = ctl.sub ? ~b_reg : b_reg;
    assign alu_sum   = {1'b0, acc} + {1'b0, b_operand} + {{DATA_W{1'b0}}, ctl.sub};

    // flags
    // on SUB the carry means no borrow
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (ctl.lf) begin
            carry <= alu_sum[DATA_W];
            zero  <= (alu_sum[DATA_W-1:0] == '0);
        end
    end

    assign acc_value = acc;
    assign alu_value = alu_sum[DATA_W-1:0];

endmodule

//--- logic/fetch_unit.sv
// program counter, memory address register, RAM with host write port, instruction register
`timescale 1ns/1ps

module fetch_unit #(
    parameter int DATA_W    = cpu_pkg::DATA_W,
    parameter int RAM_DEPTH = cpu_pkg::RAM_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       prog_we,
    input  logic [cpu_pkg::ADDR_W-1:0] prog_addr,
    input  logic [DATA_W-1:0]          prog_data,
    input  logic [DATA_W-1:0]          bus_value,
    ctrl_if.fetch                      ctl,
    output logic [cpu_pkg::ADDR_W-1:0] pc_value,
    output logic [DATA_W-1:0]          ram_value,
    output cpu_pkg::opcode_e           opcode,
    output logic [cpu_pkg::ADDR_W-1:0] operand
);
    import cpu_pkg::*;

    // RAM index width, smaller RAMs alias the upper address bits
    localparam int RAM_AW = $clog2(RAM_DEPTH);
    // opcode nibble plus operand nibble
    localparam int INSTR_W = 2 * ADDR_W;

    logic [ADDR_W-1:0]  pc;
    logic [ADDR_W-1:0]  mar;
    logic [INSTR_W-1:0] ir;
    logic [DATA_W-1:0]  mem [RAM_DEPTH];

    // program counter
    // a jump load wins over the increment
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (ctl.lp) begin
            pc <= bus_value[ADDR_W-1:0];
        end else if (ctl.cp) begin
            pc <= pc + 1'b1;
        end
    end

    // memory address register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar <= '0;
        end else if (ctl.lma) begin
            mar <= bus_value[ADDR_W-1:0];
        end
    end

    // instruction register
    // only the low byte of a wider bus carries the instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ctl.li) begin
            ir <= bus_value[INSTR_W-1:0];
        end
    end

    // RAM write port
    // host loads happen with run low, when wr never fires
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr[RAM_AW-1:0]] <= prog_data;
        end else if (ctl.wr) begin
            mem[mar[RAM_AW-1:0]] <= bus_value;
        end
    end

    // asynchronous read from the MAR
    // so lr and the IR load share one step
    assign ram_value = ctl.lr ? mem[mar[RAM_AW-1:0]] : '0;

    assign pc_value = pc;

    // undefined codes pass through and decode as NOP
    assign opcode  = opcode_e'(ir[INSTR_W-1:ADDR_W]);
    assign operand = ir[ADDR_W-1:0];

endmodule

//--- test/cpu_asserts.sv
// concurrent checks on the halted latch and the output strobe, bound into cpu_top
`timescale 1ns/1ps

module cpu_asserts (
    input logic clk,
    input logic arst_n,
    input logic out_valid,
    input logic halted
);

    // cycles since the last strobe, saturates at 7
    logic [2:0] gap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gap <= 3'd7;
        end else if (out_valid) begin
            gap <= 3'd1;
        end else if (gap != 3'd7) begin
            gap <= gap + 3'd1;
        end
    end

    // latch holds until reset
    halt_holds: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
        else $error("halted fell without a reset");

    // nothing comes out once stopped
    quiet_when_halted: assert property (
        @(posedge clk) disable iff (!arst_n) halted |-> !out_valid
    ) else $error("out_valid fired while halted");

    // at most one OUT per six-cycle instruction
    strobe_spacing: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> gap >= 3'd6
    ) else $error("out_valid pulses closer than six cycles");

    // strobe clears with the asynchronous reset
    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk(clk), .arst_n(arst_n), .out_valid(out_valid), .halted(halted)
);

//--- test/cpu_tb.sv
// accumulator CPU testbench with program loader, reference model, output checks and timeout
`timescale 1ns/1ps

module cpu_tb;

    // countdown with JZ and JMP, then JC not taken and taken
    // byte 15 holds the count
    localparam logic [127:0] LOOP_IMG = 128'h0001_fff0_907c_2e90_792d_9061_853e_901f;

    logic        clk;
    logic        arst_n;
    logic        run;
    logic        prog_we;
    logic [3:0]  prog_addr;
    logic [7:0]  prog_data;
    logic [7:0]  out_value;
    logic        out_valid;
    logic        halted;
    // program image that the model copies
    logic [7:0]  prog [16];
    logic [7:0]  exp_q [$];
    logic [31:0] rng = 32'd43836;
    int          errors = 0;
    int          base = 0;
    int          passed = 0;
    int          cycles = 0;
    int          limit = 200;

    cpu_top dut (
        .clk(clk), .arst_n(arst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .out_value(out_value), .out_valid(out_valid), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // upper LCG bits are the better ones
    function automatic logic [7:0] next_rand();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[23:16];
    endfunction

    // byte i of the image goes to address i
    task automatic set_image(input logic [127:0] img);
        for (int i = 0; i < 16; i++) begin
            prog[i] = img[i*8 +: 8];
        end
    endtask

    // instruction-level interpreter
    // queues every OUT value and returns the instruction count up to HLT
    function automatic int run_model();
        logic [7:0] m [16];
        logic [7:0] ins;
        logic [7:0] a = '0;
        logic [3:0] pc = '0;
        logic       c = 1'b0;
        logic       z = 1'b0;
        int         n;
        m = prog;
        for (n = 1; n < 200; n++) begin
            ins = m[pc];
            pc = pc + 4'd1;
            case (ins[7:4])
                4'h1: a = m[ins[3:0]];
                4'h2: {c, a} = {1'b0, a} + {1'b0, m[ins[3:0]]};
                // carry set when no borrow
                4'h3: begin
                    c = (a >= m[ins[3:0]]);
                    a = a - m[ins[3:0]];
                end
                4'h4: m[ins[3:0]] = a;
                4'h5: a = {4'h0, ins[3:0]};
                4'h6: pc = ins[3:0];
                4'h7: if (c) pc = ins[3:0];
                4'h8: if (z) pc = ins[3:0];
                4'h9: exp_q.push_back(a);
                4'hf: return n;
                // undefined codes do nothing
                default: ;
            endcase
            if (ins[7:4] == 4'h2 || ins[7:4] == 4'h3)
                z = (a == 8'd0);
        end
        return n;
    endfunction

    // reset, optional reload of RAM, model run, then raise run
    task automatic start_program(input bit reload);
        int n;
        @(posedge clk);
        arst_n <= 1'b0;
        run    <= 1'b0;
        repeat (10) @(posedge clk);
        assert (!halted && !out_valid)
        else begin
            $display("Fail %0t: reset did not clear halted and out_valid", $time);
            errors++;
        end
        arst_n <= 1'b1;
        exp_q.delete();
        // without reload the RAM keeps what the last run left
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            prog_we   <= reload;
            prog_addr <= 4'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        n = run_model();
        // six cycles per instruction plus reset, load and drain
        limit += n * 6 + 60;
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic finish_test(input string name);
        while (!halted) begin
            @(posedge clk);
        end
        // idle cycles to catch stray strobes after HLT
        repeat (12) @(posedge clk);
        assert (exp_q.size() == 0)
        else begin
            $display("%s: %0d expected outputs never appeared", name, exp_q.size());
            errors++;
        end
        if (errors == base) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - base);
        end
        base = errors;
    endtask

    // each strobe against the queue head and the cycle limit
    always @(posedge clk) begin
        cycles++;
        if (out_valid) begin
            assert (exp_q.size() != 0)
            else begin
                $display("out_valid fired at %0t when no output was expected", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                assert (out_value == exp_q[0])
                else begin
                    $display("Fail %0t: out_value %h, expected %h",
                             $time, out_value, exp_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the CPU did not halt in time", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        arst_n    <= 1'b0;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        // LDI, ADD and SUB on random data
        set_image(128'h0000_0000_0000_0000_f090_2d90_3f90_2e50);
        prog[0]  = prog[0] | (next_rand() & 8'h0f);
        prog[13] = next_rand();
        prog[14] = next_rand();
        prog[15] = next_rand();
        start_program(1'b1);
        finish_test("alu");
        // STA to 11 and LDA back, then the untouched byte at 12
        set_image(128'h0000_0000_0000_00f0_901c_901b_504b_2e50);
        prog[0]  = prog[0] | (next_rand() & 8'h0f);
        prog[12] = next_rand();
        prog[14] = next_rand();
        start_program(1'b1);
        finish_test("store_load");
        set_image(LOOP_IMG);
        prog[15] = (next_rand() % 8'd6) + 8'd2;
        start_program(1'b1);
        finish_test("branch");
        // opcodes A and E in the stream and OUTs after HLT
        set_image(128'h0000_0000_0000_0000_905f_90f0_90e3_a750);
        prog[0] = prog[0] | (next_rand() & 8'h0f);
        start_program(1'b1);
        finish_test("halt_nop");
        // reset inside the countdown and rerun from the same RAM
        set_image(LOOP_IMG);
        prog[15] = 8'd5;
        start_program(1'b1);
        while (!out_valid) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        start_program(1'b0);
        finish_test("reset_rerun");
        $display("5 tests, %0d passed, %0d failed, %0d errors", passed, 5 - passed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/cpu_pkg.sv
logic/ctrl_if.sv
logic/control_block.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/bus_unit.sv
logic/cpu_top.sv
test/cpu_asserts.sv
test/cpu_tb.sv
